// File: exePkg.sv
package exePkg;

    localparam int xlen        = 32;   // data and address width
    localparam int regAddrBits = 5;    // destination register number
    localparam int memWords    = 256;  // data memory depth in words
    localparam int memIdxBits  = $clog2(memWords);

    // integer alu operations
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluSll  = 4'd2,
        aluSlt  = 4'd3,
        aluSltu = 4'd4,
        aluXor  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluOr   = 4'd8,
        aluAnd  = 4'd9
    } aluOpT;

    // control transfer kind, brNone for plain instructions
    typedef enum logic [3:0] {
        brNone = 4'd0,
        brEq   = 4'd1,
        brNe   = 4'd2,
        brLt   = 4'd3,
        brGe   = 4'd4,
        brLtu  = 4'd5,
        brGeu  = 4'd6,
        brJal  = 4'd7,
        brJalr = 4'd8
    } branchOpT;

    typedef enum logic [1:0] {
        mulLow    = 2'd0,  // mul
        mulHigh   = 2'd1,  // mulh, both signed
        mulHighSu = 2'd2,  // mulhsu
        mulHighU  = 2'd3   // mulhu
    } mulOpT;

    typedef enum logic [3:0] {
        memNone = 4'd0,
        memLb   = 4'd1,
        memLh   = 4'd2,
        memLw   = 4'd3,
        memLbu  = 4'd4,
        memLhu  = 4'd5,
        memSb   = 4'd6,
        memSh   = 4'd7,
        memSw   = 4'd8
    } memOpT;

    // writeback source picked in stage 6
    typedef enum logic [2:0] {
        wbAlu  = 3'd0,
        wbLink = 3'd1,
        wbMul  = 3'd2,
        wbUimm = 3'd3,
        wbMem  = 3'd4
    } wbSelT;

endpackage

// File: aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  exePkg::aluOpT           aluOp,
    input  logic [exePkg::xlen-1:0] a,
    input  logic [exePkg::xlen-1:0] b,
    output logic [exePkg::xlen-1:0] result
);

    logic [4:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = b[4:0];  // rv32 shifts use five bits only
    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb
    begin
        case (aluOp)
            exePkg::aluAdd:  result = a + b;
            exePkg::aluSub:  result = a - b;
            exePkg::aluSll:  result = a << shamt;
            exePkg::aluSlt:  result = {{(exePkg::xlen-1){1'b0}}, lessSigned};
            exePkg::aluSltu: result = {{(exePkg::xlen-1){1'b0}}, lessUnsigned};
            exePkg::aluXor:  result = a ^ b;
            exePkg::aluSrl:  result = a >> shamt;
            exePkg::aluSra:  result = $signed(a) >>> shamt;  // keeps sign bit
            exePkg::aluOr:   result = a | b;
            exePkg::aluAnd:  result = a & b;
            default:         result = '0;
        endcase
    end

endmodule

// File: branchUnit.sv
`timescale 1ns/1ps

module branchUnit (
    input  exePkg::branchOpT        branchOp,
    input  logic [exePkg::xlen-1:0] a,
    input  logic [exePkg::xlen-1:0] b,
    input  logic [exePkg::xlen-1:0] pc,
    input  logic [exePkg::xlen-1:0] bImm,
    input  logic [exePkg::xlen-1:0] jImm,
    output logic                    taken,
    output logic [exePkg::xlen-1:0] target
);

    logic isEq;
    logic isLt;
    logic isLtu;

    assign isEq  = (a == b);
    assign isLt  = $signed(a) < $signed(b);
    assign isLtu = a < b;

    always_comb
    begin
        case (branchOp)
            exePkg::brEq:   taken = isEq;
            exePkg::brNe:   taken = !isEq;
            exePkg::brLt:   taken = isLt;
            exePkg::brGe:   taken = !isLt;
            exePkg::brLtu:  taken = isLtu;
            exePkg::brGeu:  taken = !isLtu;
            exePkg::brJal,
            exePkg::brJalr: taken = 1'b1;  // jumps always redirect
            default:        taken = 1'b0;
        endcase
    end

    // redirect address, word addressed pc
    always_comb
    begin
        case (branchOp)
            exePkg::brJal:  target = pc + jImm;
            exePkg::brJalr: target = a + b;  // b holds the I immediate
            default:        target = pc + bImm;
        endcase
    end

endmodule

// File: mulUnit.sv
`timescale 1ns/1ps

module mulUnit (
    input  exePkg::mulOpT           mulOp,
    input  logic [exePkg::xlen-1:0] a,
    input  logic [exePkg::xlen-1:0] b,
    output logic [exePkg::xlen-1:0] result
);

    logic                               aSigned;
    logic                               bSigned;
    logic signed [exePkg::xlen:0]       aExt;
    logic signed [exePkg::xlen:0]       bExt;
    logic signed [2*exePkg::xlen+1:0]   product;

    assign aSigned = (mulOp == exePkg::mulHigh) || (mulOp == exePkg::mulHighSu);
    assign bSigned = (mulOp == exePkg::mulHigh);

    // one extra bit per operand turns every form into a signed multiply
    assign aExt = {aSigned & a[exePkg::xlen-1], a};
    assign bExt = {bSigned & b[exePkg::xlen-1], b};

    assign product = aExt * bExt;

    assign result = (mulOp == exePkg::mulLow) ? product[exePkg::xlen-1:0]
                                              : product[2*exePkg::xlen-1:exePkg::xlen];

endmodule

// File: dataMem.sv
`timescale 1ns/1ps

module dataMem (
    input  logic                    clk,
    input  logic                    nrst,
    input  exePkg::memOpT           memOp,
    input  logic [exePkg::xlen-1:0] base,
    input  logic [exePkg::xlen-1:0] offsetLoad,
    input  logic [exePkg::xlen-1:0] offsetStore,
    input  logic [exePkg::xlen-1:0] storeData,
    output logic [exePkg::xlen-1:0] loadData,
    output logic                    misaligned
);

    logic [exePkg::xlen-1:0] mem [exePkg::memWords];

    logic                         isStore;
    logic [exePkg::xlen-1:0]      addr;
    logic [1:0]                   lane;
    logic [exePkg::memIdxBits-1:0] wordIdx;
    logic                         misalignNow;
    logic [3:0]                   byteEn;
    logic [exePkg::xlen-1:0]      storeWord;

    exePkg::memOpT                opReg5;
    logic [1:0]                   laneReg5;
    logic [exePkg::memIdxBits-1:0] idxReg5;
    logic                         misReg5;

    logic [exePkg::xlen-1:0]      rdWord;
    logic [7:0]                   byteSel;
    logic [15:0]                  halfSel;
    logic [exePkg::xlen-1:0]      loadExt;

    assign isStore = memOp inside {exePkg::memSb, exePkg::memSh, exePkg::memSw};
    assign addr    = base + (isStore ? offsetStore : offsetLoad);
    assign lane    = addr[1:0];
    assign wordIdx = addr[exePkg::memIdxBits+1:2];  // wraps modulo memWords

    always_comb
    begin
        case (memOp)
            exePkg::memLh, exePkg::memLhu, exePkg::memSh: misalignNow = addr[0];
            exePkg::memLw, exePkg::memSw:                 misalignNow = (lane != 2'b00);
            default:                                      misalignNow = 1'b0;
        endcase
    end

    // store data replicated so each lane finds its bytes in place
    always_comb
    begin
        byteEn    = 4'b0000;
        storeWord = storeData;
        case (memOp)
            exePkg::memSb:
            begin
                byteEn    = 4'b0001 << lane;
                storeWord = {4{storeData[7:0]}};
            end
            exePkg::memSh:
            begin
                byteEn    = lane[1] ? 4'b1100 : 4'b0011;
                storeWord = {2{storeData[15:0]}};
            end
            exePkg::memSw: byteEn = 4'b1111;
            default:       byteEn = 4'b0000;
        endcase
        if (misalignNow)
            byteEn = 4'b0000;  // misaligned store is dropped
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (byteEn[i])
                mem[wordIdx][8*i +: 8] <= storeWord[8*i +: 8];
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            opReg5   <= exePkg::memNone;
            laneReg5 <= '0;
            idxReg5  <= '0;
            misReg5  <= 1'b0;
        end
        else
        begin
            opReg5   <= memOp;
            laneReg5 <= lane;
            idxReg5  <= wordIdx;
            misReg5  <= misalignNow;
        end
    end

    assign rdWord  = mem[idxReg5];
    assign byteSel = rdWord[8*laneReg5 +: 8];
    assign halfSel = rdWord[16*laneReg5[1] +: 16];  // odd lane bit ignored for halves

    always_comb
    begin
        case (opReg5)
            exePkg::memLb:  loadExt = {{(exePkg::xlen-8){byteSel[7]}}, byteSel};
            exePkg::memLbu: loadExt = {{(exePkg::xlen-8){1'b0}}, byteSel};
            exePkg::memLh:  loadExt = {{(exePkg::xlen-16){halfSel[15]}}, halfSel};
            exePkg::memLhu: loadExt = {{(exePkg::xlen-16){1'b0}}, halfSel};
            exePkg::memLw:  loadExt = rdWord;
            default:        loadExt = '0;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            loadData   <= '0;
            misaligned <= 1'b0;
        end
        else
        begin
            loadData   <= loadExt;
            misaligned <= misReg5;
        end
    end

endmodule

// File: exeStage.sv
`timescale 1ns/1ps

module exeStage (
    input  logic                           clk,
    input  logic                           nrst,
    input  logic                           we,
    input  logic [exePkg::regAddrBits-1:0] rd,
    input  exePkg::wbSelT                  wbSel,
    input  exePkg::aluOpT                  aluOp,
    input  exePkg::branchOpT               branchOp,
    input  exePkg::mulOpT                  mulOp,
    input  exePkg::memOpT                  memOp,
    input  logic [exePkg::xlen-1:0]        opA,
    input  logic [exePkg::xlen-1:0]        opB,
    input  logic [exePkg::xlen-1:0]        pc,
    input  logic [exePkg::xlen-1:0]        bImm,
    input  logic [exePkg::xlen-1:0]        jImm,
    input  logic [exePkg::xlen-1:0]        uImm,
    input  logic [exePkg::xlen-1:0]        sImm,
    output logic                           wbWe,
    output logic [exePkg::regAddrBits-1:0] wbRd,
    output logic [exePkg::xlen-1:0]        wbData,
    output logic [exePkg::xlen-1:0]        target,
    output logic                           bjTaken,
    output logic                           addrMisaligned
);

    logic [exePkg::xlen-1:0]        aluRes;
    logic [exePkg::xlen-1:0]        mulRes;
    logic [exePkg::xlen-1:0]        loadData;

    // stage 5
    logic                           weReg5;
    logic [exePkg::regAddrBits-1:0] rdReg5;
    exePkg::wbSelT                  wbSelReg5;
    exePkg::branchOpT               branchOpReg5;
    exePkg::mulOpT                  mulOpReg5;
    logic [exePkg::xlen-1:0]        opAReg5;
    logic [exePkg::xlen-1:0]        opBReg5;
    logic [exePkg::xlen-1:0]        pcReg5;
    logic [exePkg::xlen-1:0]        bImmReg5;
    logic [exePkg::xlen-1:0]        jImmReg5;
    logic [exePkg::xlen-1:0]        uImmReg5;
    logic [exePkg::xlen-1:0]        aluResReg5;

    // stage 6
    exePkg::wbSelT                  wbSelReg6;
    logic [exePkg::xlen-1:0]        pcReg6;
    logic [exePkg::xlen-1:0]        uImmReg6;
    logic [exePkg::xlen-1:0]        aluResReg6;
    logic [exePkg::xlen-1:0]        mulResReg6;

    aluUnit uAlu (
        .aluOp  (aluOp),
        .a      (opA),
        .b      (opB),
        .result (aluRes)
    );

    branchUnit uBranch (
        .branchOp (branchOpReg5),
        .a        (opAReg5),
        .b        (opBReg5),
        .pc       (pcReg5),
        .bImm     (bImmReg5),
        .jImm     (jImmReg5),
        .taken    (bjTaken),  // redirect seen one cycle after issue
        .target   (target)
    );

    mulUnit uMul (
        .mulOp  (mulOpReg5),
        .a      (opAReg5),
        .b      (opBReg5),
        .result (mulRes)
    );

    dataMem uMem (
        .clk         (clk),
        .nrst        (nrst),
        .memOp       (memOp),
        .base        (opA),
        .offsetLoad  (opB),   // I immediate for loads
        .offsetStore (sImm),
        .storeData   (opB),
        .loadData    (loadData),
        .misaligned  (addrMisaligned)
    );

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            weReg5       <= 1'b0;
            rdReg5       <= '0;
            wbSelReg5    <= exePkg::wbAlu;
            branchOpReg5 <= exePkg::brNone;
            mulOpReg5    <= exePkg::mulLow;
            opAReg5      <= '0;
            opBReg5      <= '0;
            pcReg5       <= '0;
            bImmReg5     <= '0;
            jImmReg5     <= '0;
            uImmReg5     <= '0;
            aluResReg5   <= '0;
            wbWe         <= 1'b0;
            wbRd         <= '0;
            wbSelReg6    <= exePkg::wbAlu;
            pcReg6       <= '0;
            uImmReg6     <= '0;
            aluResReg6   <= '0;
            mulResReg6   <= '0;
        end
        else
        begin
            weReg5       <= we;
            rdReg5       <= rd;
            wbSelReg5    <= wbSel;
            branchOpReg5 <= branchOp;
            mulOpReg5    <= mulOp;
            opAReg5      <= opA;
            opBReg5      <= opB;
            pcReg5       <= pc;
            bImmReg5     <= bImm;
            jImmReg5     <= jImm;
            uImmReg5     <= uImm;
            aluResReg5   <= aluRes;
            wbWe         <= weReg5;  // stage 6 drives writeback directly
            wbRd         <= rdReg5;
            wbSelReg6    <= wbSelReg5;
            pcReg6       <= pcReg5;
            uImmReg6     <= uImmReg5;
            aluResReg6   <= aluResReg5;
            mulResReg6   <= mulRes;
        end
    end

    always_comb
    begin
        case (wbSelReg6)
            exePkg::wbAlu:  wbData = aluResReg6;
            exePkg::wbLink: wbData = pcReg6 + 32'd1;  // next word
            exePkg::wbMul:  wbData = mulResReg6;
            exePkg::wbUimm: wbData = uImmReg6;
            exePkg::wbMem:  wbData = loadData;
            default:        wbData = '0;
        endcase
    end

endmodule

// File: exeStageTb.sv
`timescale 1ns/1ps

module exeStageTb;

    localparam int aluCount    = 100;
    localparam int mulCount    = 60;
    localparam int brRandCount = 40;
    // about one instruction per cycle in each test and twice that for margin
    localparam int cycleLimit  = 2 * (aluCount + mulCount + brRandCount) + 200;

    logic                           clk;
    logic                           nrst;
    logic                           we;
    logic [exePkg::regAddrBits-1:0] rd;
    exePkg::wbSelT                  wbSel;
    exePkg::aluOpT                  aluOp;
    exePkg::branchOpT               branchOp;
    exePkg::mulOpT                  mulOp;
    exePkg::memOpT                  memOp;
    logic [31:0]                    opA;
    logic [31:0]                    opB;
    logic [31:0]                    pc;
    logic [31:0]                    bImm;
    logic [31:0]                    jImm;
    logic [31:0]                    uImm;
    logic [31:0]                    sImm;
    logic                           wbWe;
    logic [exePkg::regAddrBits-1:0] wbRd;
    logic [31:0]                    wbData;
    logic [31:0]                    target;
    logic                           bjTaken;
    logic                           addrMisaligned;

    // model pipe with index 0 as stage 5 and index 1 as stage 6
    logic                           expWe [2];
    logic [exePkg::regAddrBits-1:0] expRd [2];
    logic [31:0]                    expData [2];
    logic                           expMis [2];
    logic                           brTaken;
    logic [31:0]                    brTarget;
    exePkg::branchOpT               brKind;
    logic [31:0]                    shadow [exePkg::memWords];

    int    passCount = 0;
    int    failCount = 0;
    int    errBase = 0;
    int    cycleCount;
    string testName = "reset";

    exeStage DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] aluModel(input exePkg::aluOpT op, input logic [31:0] a,
                                             input logic [31:0] b);
        case (op)
            exePkg::aluAdd:  return a + b;
            exePkg::aluSub:  return a - b;
            exePkg::aluSll:  return a << b[4:0];
            exePkg::aluSlt:  return {31'b0, $signed(a) < $signed(b)};
            exePkg::aluSltu: return {31'b0, a < b};
            exePkg::aluXor:  return a ^ b;
            exePkg::aluSrl:  return a >> b[4:0];
            exePkg::aluSra:  return $signed(a) >>> b[4:0];
            exePkg::aluOr:   return a | b;
            exePkg::aluAnd:  return a & b;
            default:         return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] mulModel(input exePkg::mulOpT op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [63:0] ax;
        logic [63:0] bx;
        logic [63:0] prod;
        ax = (op == exePkg::mulHighU) ? {32'b0, a} : {{32{a[31]}}, a};
        bx = (op == exePkg::mulHigh) ? {{32{b[31]}}, b} : {32'b0, b};
        prod = ax * bx;  // 64 bit wrap keeps two's complement right
        return (op == exePkg::mulLow) ? prod[31:0] : prod[63:32];
    endfunction

    task automatic checkVal(input string field, input logic [31:0] expected,
                            input logic [31:0] actual);
        assert (actual === expected) passCount++;
        else
        begin
            failCount++;
            $display("error test %s %s: expected %h actual %h", testName, field, expected,
                     actual);
        end
    endtask

    task automatic clearModel();
        for (int i = 0; i < 2; i++)
        begin
            expWe[i]   = 1'b0;
            expRd[i]   = '0;
            expData[i] = '0;
            expMis[i]  = 1'b0;
        end
        brTaken  = 1'b0;
        brTarget = '0;
        brKind   = exePkg::brNone;
    endtask

    // reference for the instruction sampled at this edge
    task automatic modelIssue();
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] byteV;
        logic [31:0] halfV;
        logic [31:0] loadVal;
        logic [31:0] data;
        logic        isStore;
        logic        mis;
        int          idx;
        isStore = memOp inside {exePkg::memSb, exePkg::memSh, exePkg::memSw};
        addr    = opA + (isStore ? sImm : opB);
        idx     = int'((addr >> 2) % exePkg::memWords);
        mis     = ((memOp inside {exePkg::memLh, exePkg::memLhu, exePkg::memSh}) && addr[0])
               || ((memOp inside {exePkg::memLw, exePkg::memSw}) && addr[1:0] != 2'b00);
        word    = shadow[idx];
        byteV   = word >> (8 * addr[1:0]);
        halfV   = word >> (16 * addr[1]);
        loadVal = '0;
        case (memOp)
            exePkg::memLb:  loadVal = {{24{byteV[7]}}, byteV[7:0]};
            exePkg::memLbu: loadVal = {24'b0, byteV[7:0]};
            exePkg::memLh:  loadVal = {{16{halfV[15]}}, halfV[15:0]};
            exePkg::memLhu: loadVal = {16'b0, halfV[15:0]};
            exePkg::memLw:  loadVal = word;
            exePkg::memSb:  shadow[idx][8*addr[1:0] +: 8] = opB[7:0];
            exePkg::memSh:  if (!mis) shadow[idx][16*addr[1] +: 16] = opB[15:0];
            exePkg::memSw:  if (!mis) shadow[idx] = opB;
            default:        loadVal = '0;
        endcase
        case (wbSel)
            exePkg::wbAlu:  data = aluModel(aluOp, opA, opB);
            exePkg::wbLink: data = pc + 32'd1;  // word addressed pc
            exePkg::wbMul:  data = mulModel(mulOp, opA, opB);
            exePkg::wbUimm: data = uImm;
            exePkg::wbMem:  data = loadVal;
            default:        data = '0;
        endcase
        case (branchOp)
            exePkg::brEq:   brTaken = (opA == opB);
            exePkg::brNe:   brTaken = (opA != opB);
            exePkg::brLt:   brTaken = ($signed(opA) < $signed(opB));
            exePkg::brGe:   brTaken = ($signed(opA) >= $signed(opB));
            exePkg::brLtu:  brTaken = (opA < opB);
            exePkg::brGeu:  brTaken = (opA >= opB);
            exePkg::brJal,
            exePkg::brJalr: brTaken = 1'b1;
            default:        brTaken = 1'b0;
        endcase
        if (branchOp == exePkg::brJal)
            brTarget = pc + jImm;
        else if (branchOp == exePkg::brJalr)
            brTarget = opA + opB;
        else
            brTarget = pc + bImm;
        brKind     = branchOp;
        expWe[1]   = expWe[0];
        expRd[1]   = expRd[0];
        expData[1] = expData[0];
        expMis[1]  = expMis[0];
        expWe[0]   = we;
        expRd[0]   = rd;
        expData[0] = data;
        expMis[0]  = mis;
    endtask

    always @(posedge clk)
    begin
        if (!nrst)
            clearModel();
        checkVal("wbWe", 32'(expWe[1]), 32'(wbWe));
        checkVal("wbRd", 32'(expRd[1]), 32'(wbRd));
        checkVal("wbData", expData[1], wbData);
        checkVal("addrMisaligned", 32'(expMis[1]), 32'(addrMisaligned));
        checkVal("bjTaken", 32'(brTaken), 32'(bjTaken));
        if (brKind != exePkg::brNone)
            checkVal("target", brTarget, target);
        if (nrst)
            modelIssue();
    end

    task automatic clearInputs();
        we       = 1'b0;
        rd       = '0;
        wbSel    = exePkg::wbAlu;
        aluOp    = exePkg::aluAdd;
        branchOp = exePkg::brNone;
        mulOp    = exePkg::mulLow;
        memOp    = exePkg::memNone;
        opA      = '0;
        opB      = '0;
        pc       = '0;
        bImm     = '0;
        jImm     = '0;
        uImm     = '0;
        sImm     = '0;
    endtask

    // op fields and sImm are set by the caller beforehand
    task automatic issue(input exePkg::wbSelT sel, input logic wen, input logic [31:0] a,
                         input logic [31:0] b);
        logic [31:0] rnd;
        rnd   = $urandom;
        we    = wen;
        rd    = rnd[exePkg::regAddrBits-1:0];
        wbSel = sel;
        opA   = a;
        opB   = b;
        pc    = $urandom;
        bImm  = $urandom;
        jImm  = $urandom;
        uImm  = $urandom;
        @(negedge clk);
        clearInputs();
    endtask

    task automatic finishTest();
        int errs;
        clearInputs();
        repeat (3) @(negedge clk);  // let the pipe drain into the checks
        errs = failCount - errBase;
        $display("test %s done with %0d errors", testName, errs);
        errBase = failCount;
    endtask

    task automatic branchTest();
        logic [31:0] aVals [5];
        logic [31:0] bVals [5];
        aVals = '{32'd5, 32'd3, 32'd7, 32'hffff_ffff, 32'd1};
        bVals = '{32'd5, 32'd7, 32'd3, 32'd1, 32'hffff_ffff};
        testName = "branch";
        for (int op = 1; op <= 6; op++)
        begin
            for (int i = 0; i < 5; i++)
            begin
                branchOp = exePkg::branchOpT'(op);
                issue(exePkg::wbAlu, 1'b0, aVals[i], bVals[i]);
            end
        end
        for (int i = 0; i < 8; i++)
        begin
            branchOp = (i % 2 == 1) ? exePkg::brJalr : exePkg::brJal;
            issue(exePkg::wbLink, 1'b1, $urandom, $urandom);
        end
        for (int i = 0; i < brRandCount; i++)
        begin
            branchOp = exePkg::branchOpT'($urandom_range(8));
            issue(exePkg::wbLink, 1'b1, $urandom_range(3) - 1, $urandom_range(3) - 1);
        end
        finishTest();
    endtask

    task automatic memTest();
        logic [31:0] base;
        base = 32'h80;
        testName = "memory";
        for (int w = 0; w < 4; w++)
        begin
            memOp = exePkg::memSw;
            sImm  = 4 * w;
            issue(exePkg::wbMem, 1'b0, base, $urandom);
        end
        for (int l = 0; l < 4; l++)
        begin
            memOp = exePkg::memLb;
            issue(exePkg::wbMem, 1'b1, base, 5 * l);  // lane l of word l
            memOp = exePkg::memLbu;
            issue(exePkg::wbMem, 1'b1, base, 5 * l);
            if (l % 2 == 0)
            begin
                memOp = exePkg::memLh;
                issue(exePkg::wbMem, 1'b1, base, 5 * l);
                memOp = exePkg::memLhu;
                issue(exePkg::wbMem, 1'b1, base, 5 * l);
            end
            memOp = exePkg::memLw;
            issue(exePkg::wbMem, 1'b1, base, 4 * l);
        end
        // each store followed at once by a load of the same word
        for (int l = 0; l < 4; l++)
        begin
            memOp = exePkg::memSb;
            sImm  = 16 + l;
            issue(exePkg::wbMem, 1'b0, base, $urandom);
            memOp = exePkg::memLb;
            issue(exePkg::wbMem, 1'b1, base, 16 + l);
        end
        for (int h = 0; h < 4; h += 2)
        begin
            memOp = exePkg::memSh;
            sImm  = 20 + h;
            issue(exePkg::wbMem, 1'b0, base, $urandom);
            memOp = exePkg::memLhu;
            issue(exePkg::wbMem, 1'b1, base, 20 + h);
        end
        memOp = exePkg::memSw;
        sImm  = 24;
        issue(exePkg::wbMem, 1'b0, base, $urandom);
        memOp = exePkg::memLw;
        issue(exePkg::wbMem, 1'b1, base, 24);
        repeat (4) issue(exePkg::wbUimm, 1'b1, $urandom, $urandom);
        finishTest();
    endtask

    task automatic misalignTest();
        testName = "misalign";
        for (int off = 1; off < 4; off++)
        begin
            memOp = exePkg::memLw;
            issue(exePkg::wbUimm, 1'b1, 32'h80, off);
            memOp = (off == 2) ? exePkg::memLhu : exePkg::memLh;
            issue(exePkg::wbUimm, 1'b1, 32'h80, off);
        end
        memOp = exePkg::memSh;
        sImm  = 5;
        issue(exePkg::wbUimm, 1'b0, 32'h80, $urandom);
        memOp = exePkg::memSw;
        sImm  = 6;
        issue(exePkg::wbUimm, 1'b0, 32'h80, $urandom);
        memOp = exePkg::memLw;  // word 1 must be unchanged
        issue(exePkg::wbMem, 1'b1, 32'h80, 4);
        finishTest();
    endtask

    initial
    begin
        cycleCount = 0;
        while (cycleCount < cycleLimit)
        begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, the run hung", cycleCount);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        void'($urandom(43318));
        nrst = 1'b1;
        clearInputs();
        #1 nrst = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        finishTest();
        testName = "alu";
        repeat (aluCount)
        begin
            aluOp = exePkg::aluOpT'($urandom_range(9));
            issue(exePkg::wbAlu, 1'b1, $urandom, $urandom);
        end
        finishTest();
        testName = "multiply";
        repeat (mulCount)
        begin
            mulOp = exePkg::mulOpT'($urandom_range(3));
            issue(exePkg::wbMul, 1'b1, $urandom, $urandom);
        end
        finishTest();
        branchTest();
        memTest();
        misalignTest();
        $display("checks passed %0d failed %0d", passCount, failCount);
        if (failCount == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: sim.f
exePkg.sv
aluUnit.sv
branchUnit.sv
mulUnit.sv
dataMem.sv
exeStage.sv
exeStageTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= exeStageTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
